// ==== hdl/render_defs.svh ====
`ifndef RENDER_DEFS_SVH
`define RENDER_DEFS_SVH

// Coordinate arithmetic width, wraps at 2048
`define COORD_W 11

// Screen geometry
`define SCREEN_WIDTH 640
`define FLOOR_Y 240
`define OBSTACLE_OFFSET 250

// Goose placement and size
`define GOOSE_X 50
`define GOOSE_W 16
`define GOOSE_H 16

// Emblem obstacle size
`define EMBLEM_W 40
`define EMBLEM_H 48

`define COLOR_BITS 3 // Bits per ROM pixel

`endif

// ==== hdl/render_pkg.sv ====
`include "render_defs.svh"

package render_pkg;

    typedef enum logic [`COLOR_BITS-1:0] {
        COLOR_TRANSPARENT = 3'd0,
        COLOR_GOOSE_BODY  = 3'd1,
        COLOR_BLACK       = 3'd2,
        COLOR_BEAK        = 3'd3,
        COLOR_GOLD        = 3'd4,
        COLOR_WHITE       = 3'd5,
        COLOR_RED         = 3'd6
    } color_idx_e;

    typedef struct packed {
        logic [1:0] r;
        logic [1:0] g;
        logic [1:0] b;
    } rgb_t;

    typedef struct packed {
        logic opaque;
        rgb_t color;
    } layer_pixel_t;

    typedef struct packed {
        logic [9:0] haddr;
        logic [9:0] vaddr;
        logic       display_on;
    } beam_t;

    function automatic rgb_t palette(input color_idx_e idx);
        case (idx)
            COLOR_GOOSE_BODY: palette = '{r: 2'd2, g: 2'd2, b: 2'd1}; // Brown
            COLOR_BLACK:      palette = '{r: 2'd0, g: 2'd0, b: 2'd0};
            COLOR_BEAK:       palette = '{r: 2'd3, g: 2'd2, b: 2'd1}; // Orange
            COLOR_GOLD:       palette = '{r: 2'd3, g: 2'd2, b: 2'd0};
            COLOR_WHITE:      palette = '{r: 2'd3, g: 2'd3, b: 2'd3};
            COLOR_RED:        palette = '{r: 2'd2, g: 2'd0, b: 2'd0};
            default:          palette = '{r: 2'd0, g: 2'd0, b: 2'd0};
        endcase
    endfunction

endpackage

// ==== hdl/goose_sprite.sv ====
`timescale 1ns/1ps
`include "render_defs.svh"

module goose_sprite (
    input  logic                     clk,
    input  logic                     sys_rst,
    input  render_pkg::beam_t        beam,
    input  logic [6:0]               jump_pos,
    input  logic                     game_start_blink,
    input  logic                     game_over,
    output render_pkg::layer_pixel_t goose_px
);
    import render_pkg::*;

    logic [`COLOR_BITS*`GOOSE_W-1:0] goose_rom [0:`GOOSE_H-1];

    logic [`COORD_W-1:0]             h_pos;
    logic [`COORD_W-1:0]             v_pos;
    logic [`COORD_W-1:0]             goose_top;
    logic                            in_bounds;
    logic [3:0]                      col;
    logic [3:0]                      row;
    logic [`COLOR_BITS*`GOOSE_W-1:0] row_bits;
    color_idx_e                      idx;
    color_idx_e                      shown_idx;
    logic                            opaque;

    initial $readmemb("hdl/goose_rom.mem", goose_rom);

    assign h_pos = {1'b0, beam.haddr};
    assign v_pos = {1'b0, beam.vaddr};

    // Feet sit on the floor when jump_pos is 0
    assign goose_top = `COORD_W'(`FLOOR_Y - `GOOSE_H) - {{(`COORD_W-7){1'b0}}, jump_pos};

    assign in_bounds = (h_pos >= `COORD_W'(`GOOSE_X)) &&
                       (h_pos < `COORD_W'(`GOOSE_X + `GOOSE_W)) &&
                       (v_pos >= goose_top) && (v_pos < goose_top + `COORD_W'(`GOOSE_H));

    assign col      = 4'(h_pos - `COORD_W'(`GOOSE_X));
    assign row      = 4'(v_pos - goose_top);
    assign row_bits = goose_rom[row];
    assign idx      = color_idx_e'(row_bits[`COLOR_BITS*(`GOOSE_W-1-col) +: `COLOR_BITS]); // Col 0 at MSB end

    assign opaque    = in_bounds && game_start_blink && beam.display_on &&
                       (idx != COLOR_TRANSPARENT);
    assign shown_idx = game_over ? COLOR_RED : idx;

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            goose_px <= '0;
        end else begin
            goose_px.opaque <= opaque;
            goose_px.color  <= opaque ? palette(shown_idx) : '0;
        end
    end

endmodule

// ==== hdl/emblem_sprite.sv ====
`timescale 1ns/1ps
`include "render_defs.svh"

module emblem_sprite (
    input  logic                     clk,
    input  logic                     sys_rst,
    input  render_pkg::beam_t        beam,
    input  logic [10:0]              scrolladdr,
    input  logic                     obstacle_active,
    output render_pkg::layer_pixel_t emblem_px
);
    import render_pkg::*;

    logic [`COLOR_BITS*`EMBLEM_W-1:0] emblem_rom [0:`EMBLEM_H-1];

    logic [`COORD_W-1:0]              h_pos;
    logic [`COORD_W-1:0]              v_pos;
    logic [`COORD_W-1:0]              emblem_left;
    logic [`COORD_W-1:0]              x_off;
    logic                             in_x;
    logic                             in_y;
    logic [5:0]                       col;
    logic [5:0]                       row;
    logic [`COLOR_BITS*`EMBLEM_W-1:0] row_bits;
    color_idx_e                       idx;
    logic                             opaque;

    initial $readmemb("hdl/emblem_rom.mem", emblem_rom);

    assign h_pos = {1'b0, beam.haddr};
    assign v_pos = {1'b0, beam.vaddr};

    // Obstacle moves left as the scroll position grows, mod 2048
    assign emblem_left = `COORD_W'(`SCREEN_WIDTH) - scrolladdr + `COORD_W'(`OBSTACLE_OFFSET);

    // Offset compare keeps the box intact across the wrap point
    assign x_off = h_pos - emblem_left;
    assign in_x  = x_off < `COORD_W'(`EMBLEM_W);
    assign in_y  = (v_pos >= `COORD_W'(`FLOOR_Y - `EMBLEM_H)) && (v_pos < `COORD_W'(`FLOOR_Y));

    assign col      = 6'(x_off);
    assign row      = 6'(v_pos - `COORD_W'(`FLOOR_Y - `EMBLEM_H));
    assign row_bits = emblem_rom[row];
    assign idx      = color_idx_e'(row_bits[`COLOR_BITS*(`EMBLEM_W-1-col) +: `COLOR_BITS]);

    assign opaque = in_x && in_y && obstacle_active && beam.display_on &&
                    (idx != COLOR_TRANSPARENT);

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            emblem_px <= '0;
        end else begin
            emblem_px.opaque <= opaque;
            emblem_px.color  <= opaque ? palette(idx) : '0;
        end
    end

endmodule

// ==== hdl/layer_compositor.sv ====
`timescale 1ns/1ps
`include "render_defs.svh"

module layer_compositor (
    input  logic                     clk,
    input  logic                     sys_rst,
    input  render_pkg::beam_t        beam,
    input  render_pkg::layer_pixel_t goose_px,
    input  render_pkg::layer_pixel_t emblem_px,
    output render_pkg::rgb_t         pixel,
    output logic                     collision
);
    import render_pkg::*;

    layer_pixel_t bg_d;
    layer_pixel_t bg_q;
    rgb_t         mixed;

    always_comb begin
        bg_d = '0;
        if (beam.display_on) begin
            bg_d.opaque = 1'b1;
            if ({1'b0, beam.vaddr} < `COORD_W'(`FLOOR_Y)) begin
                bg_d.color = rgb_t'{r: 2'd0, g: 2'd3, b: 2'd3}; // Sky
            end else begin
                bg_d.color = rgb_t'{r: 2'd1, g: 2'd1, b: 2'd1}; // Floor
            end
        end
    end

    // Lines up with the registered sprite pixels
    always_ff @(posedge clk) begin
        if (sys_rst) begin
            bg_q <= '0;
        end else begin
            bg_q <= bg_d;
        end
    end

    always_comb begin
        if (goose_px.opaque) mixed = goose_px.color;
        else if (emblem_px.opaque) mixed = emblem_px.color;
        else if (bg_q.opaque) mixed = bg_q.color;
        else mixed = '0;
    end

    assign pixel     = beam.display_on ? mixed : '0; // Blank on current display_on
    assign collision = goose_px.opaque && emblem_px.opaque;

endmodule

// ==== hdl/goose_render_top.sv ====
`timescale 1ns/1ps

module goose_render_top (
    input  logic        clk,
    input  logic        sys_rst,
    input  logic        game_over,
    input  logic        game_start_blink,
    input  logic        obstacle_active,
    input  logic [6:0]  jump_pos,
    input  logic [9:0]  vaddr,
    input  logic [9:0]  haddr,
    input  logic [10:0] scrolladdr,
    input  logic        display_on,
    output logic [1:0]  R,
    output logic [1:0]  G,
    output logic [1:0]  B,
    output logic        collision
);
    import render_pkg::*;

    beam_t        beam;
    layer_pixel_t goose_px;
    layer_pixel_t emblem_px;
    rgb_t         pixel;

    assign beam = '{haddr: haddr, vaddr: vaddr, display_on: display_on};

    goose_sprite goose_sprite_i (
        .clk              (clk),
        .sys_rst          (sys_rst),
        .beam             (beam),
        .jump_pos         (jump_pos),
        .game_start_blink (game_start_blink),
        .game_over        (game_over),
        .goose_px         (goose_px)
    );

    emblem_sprite emblem_sprite_i (
        .clk             (clk),
        .sys_rst         (sys_rst),
        .beam            (beam),
        .scrolladdr      (scrolladdr),
        .obstacle_active (obstacle_active),
        .emblem_px       (emblem_px)
    );

    layer_compositor layer_compositor_i (
        .clk       (clk),
        .sys_rst   (sys_rst),
        .beam      (beam),
        .goose_px  (goose_px),
        .emblem_px (emblem_px),
        .pixel     (pixel),
        .collision (collision)
    );

    assign R = pixel.r;
    assign G = pixel.g;
    assign B = pixel.b;

endmodule

// ==== bench/goose_render_props.sv ====
`timescale 1ns/1ps

module goose_render_props (
    input logic       clk,
    input logic       sys_rst,
    input logic       display_on,
    input logic [1:0] R,
    input logic [1:0] G,
    input logic [1:0] B,
    input logic       collision
);

    blank_when_off: assert property (@(posedge clk)
        !display_on |-> (R == 2'd0 && G == 2'd0 && B == 2'd0))
        else $error("RGB not zero while display_on is low");

    // Sprite registers saw display_on low, so nothing is opaque
    no_collision_after_blank: assert property (@(posedge clk) disable iff (sys_rst)
        !display_on |=> !collision)
        else $error("collision high one cycle after display_on low");

    no_collision_after_reset: assert property (@(posedge clk) sys_rst |=> !collision)
        else $error("collision high in the first clock after reset");

endmodule

bind goose_render_top goose_render_props props_i (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .display_on (display_on),
    .R          (R),
    .G          (G),
    .B          (B),
    .collision  (collision)
);

// ==== bench/goose_render_tb.sv ====
`timescale 1ns/1ps
`include "render_defs.svh"

module goose_render_tb;

    logic        clk;
    logic        sys_rst;
    logic        game_over;
    logic        game_start_blink;
    logic        obstacle_active;
    logic [6:0]  jump_pos;
    logic [9:0]  vaddr;
    logic [9:0]  haddr;
    logic [10:0] scrolladdr;
    logic        display_on;
    logic [1:0]  R;
    logic [1:0]  G;
    logic [1:0]  B;
    logic        collision;

    logic [`COLOR_BITS*`GOOSE_W-1:0]  goose_img [0:`GOOSE_H-1];
    logic [`COLOR_BITS*`EMBLEM_W-1:0] emblem_img [0:`EMBLEM_H-1];
    logic [15:0] lfsr;
    int          checks;
    int          errors;

    goose_render_top dut_i (.*);

    always #5 clk = ~clk;

    initial begin
        repeat (5) @(posedge clk);
        @(negedge clk);
        sys_rst = 1'b0;
    end

    // Galois LFSR, taps 16 14 13 11
    function automatic int rand_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            val = (val << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic logic [5:0] color_of(input int idx);
        case (idx)
            1: return 6'b10_10_01;
            3: return 6'b11_10_01;
            4: return 6'b11_10_00;
            5: return 6'b11_11_11;
            6: return 6'b10_00_00;
            default: return 6'b00_00_00;
        endcase
    endfunction

    // Leftmost pixel sits in the top bits of a row
    function automatic int goose_index(input int row, input int col);
        return int'(goose_img[row][`COLOR_BITS*(`GOOSE_W-1-col) +: `COLOR_BITS]);
    endfunction

    function automatic int emblem_index(input int row, input int col);
        return int'(emblem_img[row][`COLOR_BITS*(`EMBLEM_W-1-col) +: `COLOR_BITS]);
    endfunction

    // {collision, R, G, B} for the inputs now applied
    function automatic logic [6:0] expected_out();
        int         h;
        int         v;
        int         top;
        int         left;
        int         dx;
        int         gi;
        int         ei;
        logic       g_op;
        logic       e_op;
        logic [5:0] rgb;
        h = int'(haddr);
        v = int'(vaddr);
        top = `FLOOR_Y - `GOOSE_H - int'(jump_pos);
        left = (`SCREEN_WIDTH - int'(scrolladdr) + `OBSTACLE_OFFSET) & 2047;
        dx = (h - left) & 2047;
        gi = 0;
        ei = 0;
        if (h >= `GOOSE_X && h < `GOOSE_X + `GOOSE_W && v >= top && v < top + `GOOSE_H) begin
            gi = goose_index(v - top, h - `GOOSE_X);
        end
        if (dx < `EMBLEM_W && v >= `FLOOR_Y - `EMBLEM_H && v < `FLOOR_Y) begin
            ei = emblem_index(v - (`FLOOR_Y - `EMBLEM_H), dx);
        end
        g_op = display_on && game_start_blink && (gi != 0);
        e_op = display_on && obstacle_active && (ei != 0);
        if (!display_on) begin
            rgb = 6'b00_00_00;
        end else if (g_op) begin
            rgb = game_over ? color_of(6) : color_of(gi);
        end else if (e_op) begin
            rgb = color_of(ei);
        end else if (v < `FLOOR_Y) begin
            rgb = 6'b00_11_11; // Sky
        end else begin
            rgb = 6'b01_01_01;
        end
        return {g_op && e_op, rgb};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    task automatic probe(input string name, input int h, input int v, input logic disp);
        logic [6:0] exp;
        haddr = 10'(h);
        vaddr = 10'(v);
        display_on = disp;
        repeat (2) @(posedge clk);
        @(negedge clk);
        exp = expected_out();
        check_value({name, " rgb"}, 32'(exp[5:0]), 32'({R, G, B}));
        check_value({name, " collision"}, 32'(exp[6]), 32'(collision));
    endtask

    task automatic test_background();
        game_start_blink = 1'b0;
        obstacle_active = 1'b0;
        probe("background", 300, `FLOOR_Y - 1, 1'b1);
        probe("background", 300, `FLOOR_Y, 1'b1);
        for (int i = 0; i < 24; i++) begin
            probe("background", rand_bits(10) % `SCREEN_WIDTH, rand_bits(9) % 480, 1'b1);
        end
    endtask

    task automatic test_blanking();
        game_start_blink = 1'b1;
        obstacle_active = 1'b1;
        scrolladdr = 11'(`SCREEN_WIDTH + `OBSTACLE_OFFSET - `GOOSE_X); // Emblem over goose
        for (int i = 0; i < 16; i++) begin
            probe("blanking", `GOOSE_X + rand_bits(4), `FLOOR_Y - `GOOSE_H + rand_bits(4), 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            probe("blanking", rand_bits(10) % `SCREEN_WIDTH, rand_bits(9) % 480, 1'b0);
        end
    endtask

    task automatic test_goose_image();
        obstacle_active = 1'b0;
        game_over = 1'b0;
        jump_pos = 7'd0;
        for (int b = 1; b >= 0; b--) begin
            game_start_blink = 1'(b);
            for (int r = 0; r < `GOOSE_H; r++) begin
                for (int c = 0; c < `GOOSE_W; c++) begin
                    probe("goose_image", `GOOSE_X + c, `FLOOR_Y - `GOOSE_H + r, 1'b1);
                end
            end
        end
    endtask

    task automatic test_jump_game_over();
        int top;
        obstacle_active = 1'b0;
        game_start_blink = 1'b1;
        for (int i = 0; i < 6; i++) begin
            jump_pos = 7'(rand_bits(7));
            game_over = 1'(i % 2);
            top = `FLOOR_Y - `GOOSE_H - int'(jump_pos);
            // Columns where the first or last image row is opaque
            probe("jump", `GOOSE_X + 11, top - 1, 1'b1);
            probe("jump", `GOOSE_X + 8, top + `GOOSE_H, 1'b1);
            for (int j = 0; j < 12; j++) begin
                probe("jump", `GOOSE_X + rand_bits(4), top + rand_bits(4), 1'b1);
            end
        end
        // Whole box in red
        game_over = 1'b1;
        top = `FLOOR_Y - `GOOSE_H - int'(jump_pos);
        for (int r = 0; r < `GOOSE_H; r++) begin
            for (int c = 0; c < `GOOSE_W; c++) begin
                probe("game_over", `GOOSE_X + c, top + r, 1'b1);
            end
        end
        game_over = 1'b0;
    endtask

    task automatic test_emblem();
        int left;
        game_start_blink = 1'b1;
        jump_pos = 7'd0;
        obstacle_active = 1'b1;
        for (int i = 0; i < 4; i++) begin
            left = (i == 0) ? `GOOSE_X : rand_bits(10) % (`SCREEN_WIDTH - `EMBLEM_W);
            scrolladdr = 11'(`SCREEN_WIDTH + `OBSTACLE_OFFSET - left);
            for (int j = 0; j < 40; j++) begin
                probe("emblem", left + rand_bits(6) % `EMBLEM_W,
                      `FLOOR_Y - `EMBLEM_H + rand_bits(6) % `EMBLEM_H, 1'b1);
            end
        end
        // Full overlap with the goose box
        scrolladdr = 11'(`SCREEN_WIDTH + `OBSTACLE_OFFSET - `GOOSE_X);
        for (int r = 0; r < `GOOSE_H; r++) begin
            for (int c = 0; c < `GOOSE_W; c++) begin
                probe("priority", `GOOSE_X + c, `FLOOR_Y - `GOOSE_H + r, 1'b1);
            end
        end
        obstacle_active = 1'b0;
        for (int j = 0; j < 16; j++) begin
            probe("obstacle_off", `GOOSE_X + rand_bits(4), `FLOOR_Y - `GOOSE_H + rand_bits(4), 1'b1);
        end
    endtask

    initial begin
        int wait_cycles;
        clk = 1'b0;
        sys_rst = 1'b1;
        game_over = 1'b0;
        game_start_blink = 1'b0;
        obstacle_active = 1'b0;
        jump_pos = 7'd0;
        vaddr = 10'd0;
        haddr = 10'd0;
        scrolladdr = 11'd0;
        display_on = 1'b1;
        lfsr = 16'd75;
        checks = 0;
        errors = 0;
        $readmemb("hdl/goose_rom.mem", goose_img);
        $readmemb("hdl/emblem_rom.mem", emblem_img);
        wait_cycles = 0;
        while (sys_rst && wait_cycles < 20) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (sys_rst) begin
            $display("reset was never released, no test was run");
            errors++;
        end else begin
            test_background();
            test_blanking();
            test_goose_image();
            test_jump_game_over();
            test_emblem();
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== goose_render.f ====
+incdir+hdl
hdl/render_pkg.sv
hdl/goose_sprite.sv
hdl/emblem_sprite.sv
hdl/layer_compositor.sv
hdl/goose_render_top.sv
bench/goose_render_props.sv
bench/goose_render_tb.sv

// ==== Makefile ====
sim:
	verilator --binary --timing --assert --top-module goose_render_tb -f goose_render.f -o goose_render_sim
	./obj_dir/goose_render_sim > sim.log 2>&1 || echo "SOME TESTS FAILED" >> sim.log
	@cat sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== hdl/goose_rom.mem ====
// One row per line, 16 pixels of 3 bits, leftmost pixel first
000000000000000000000000000000001001001000000000
000000000000000000000000000001001010001011000000
000000000000000000000000000001001001001011011000
000000000000000000000000000000001001000000000000
000000000000000000000000000000001001000000000000
000000000000000000000000000000001001000000000000
001000000000000000000000000001001001000000000000
001001000000000001001001001001001001000000000000
001001001001001001001001001001001001000000000000
000001001001001101101101101001001001000000000000
000001001001001001101101001001001000000000000000
000000001001001001001001001001000000000000000000
000000000000010010000010010000000000000000000000
000000000000000011000000011000000000000000000000
000000000000000011000000011000000000000000000000
000000000000011011000000011011000000000000000000

// ==== hdl/emblem_rom.mem ====
// One row per line, 40 pixels of 3 bits, leftmost pixel first
000000000000000000000000100100100100100100100100100100100100100100100100100100100100100100100100000000000000000000000000
000000000000000000000000100100100100100100100100100100100100100100100100100100100100100100100100000000000000000000000000
000000000000000000000000100100100100100100100100100100100100100100100100100100100100100100100100000000000000000000000000
000000000000000000000000100100100100100100100100100100100100100100100100100100100100100100100100000000000000000000000000
000000100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100000000
000000100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100000000
000000100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100000000
000000100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100000000
000000100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100000000
000000100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100000000
000000100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100000000
000000100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100000000
100100100100100100100100100101101101101101101101010010010010010010010010101101101101101101101100100100100100100100100100
100100100100100100100100100101101101101101101101010010010010010010010010101101101101101101101100100100100100100100100100
100100100100100100100100100101101101101101101101010010010010010010010010101101101101101101101100100100100100100100100100
100100100100100100100100100101101101101101101101010010010010010010010010101101101101101101101100100100100100100100100100
100100100100100100100100100101101101101101101101010010010010010010010010101101101101101101101100100100100100100100100100
100100100100100100100100100101101101101101101101010010010010010010010010101101101101101101101100100100100100100100100100
100100100100100100100100100101101101101101101101010010010010010010010010101101101101101101101100100100100100100100100100
100100100100100100100100100101101101101101101101010010010010010010010010101101101101101101101100100100100100100100100100
100100100100100100100100100101101101101101101101010010010010010010010010101101101101101101101100100100100100100100100100
100100100100100100100100100101101101101101101101010010010010010010010010101101101101101101101100100100100100100100100100
100100100100100100100100100101101101101101101101010010010010010010010010101101101101101101101100100100100100100100100100
100100100100100100100100100101101101101101101101010010010010010010010010101101101101101101101100100100100100100100100100
100100100100100100100100100101101101101101101101010010010010010010010010101101101101101101101100100100100100100100100100
100100100100100100100100100101101101101101101101010010010010010010010010101101101101101101101100100100100100100100100100
100100100100100100100100100101101101101101101101010010010010010010010010101101101101101101101100100100100100100100100100
100100100100100100100100100101101101101101101101010010010010010010010010101101101101101101101100100100100100100100100100
100100100100100100100100100101101101101101101101010010010010010010010010101101101101101101101100100100100100100100100100
100100100100100100100100100101101101101101101101010010010010010010010010101101101101101101101100100100100100100100100100
100100100100100100100100100101101101101101101101010010010010010010010010101101101101101101101100100100100100100100100100
100100100100100100100100100101101101101101101101010010010010010010010010101101101101101101101100100100100100100100100100
100100100100100100100100100101101101101101101101010010010010010010010010101101101101101101101100100100100100100100100100
100100100100100100100100100101101101101101101101010010010010010010010010101101101101101101101100100100100100100100100100
100100100100100100100100100101101101101101101101010010010010010010010010101101101101101101101100100100100100100100100100
100100100100100100100100100101101101101101101101010010010010010010010010101101101101101101101100100100100100100100100100
000000100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100000000
000000100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100000000
000000100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100000000
000000100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100000000
000000100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100000000
000000100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100000000
000000100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100000000
000000100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100100000000
000000000000000000000000100100100100100100100100100100100100100100100100100100100100100100100100000000000000000000000000
000000000000000000000000100100100100100100100100100100100100100100100100100100100100100100100100000000000000000000000000
000000000000000000000000100100100100100100100100100100100100100100100100100100100100100100100100000000000000000000000000
000000000000000000000000100100100100100100100100100100100100100100100100100100100100100100100100000000000000000000000000
